// ==== compile.f ====
src/rp_analog_pkg.sv
src/adc_frontend.sv
src/dac_backend.sv
src/hk_regs.sv
src/pwm_dac.sv
src/rp_analog_top.sv
test/tb_rp_analog_top.sv

// ==== Bender.yml ====
package:
  name: rp_analog

sources:
  - files:
      - src/rp_analog_pkg.sv
      - src/adc_frontend.sv
      - src/dac_backend.sv
      - src/hk_regs.sv
      - src/pwm_dac.sv
      - src/rp_analog_top.sv
  - target: test
    files:
      - test/tb_rp_analog_top.sv

// ==== test/tb_rp_analog_top.sv ====
// Testbench for the analog signal path top
// Random and corner stimulus, expected values from reference functions,
// outputs checked in a separate compare process

`timescale 1ns/1ps

module tb_rp_analog_top
  import rp_analog_pkg::*;
();

  localparam int PWM_CNT      = 4;
  localparam int BUS_TIMEOUT  = 16;   // Cycles to wait for ack
  localparam int WRAP_TIMEOUT = 300;  // Longer than one PWM period
  localparam int SMP_MAX      = (1 << (SMP_W-1)) - 1;
  localparam int SMP_MIN      = -SMP_MAX - 1;

  logic                    adc_clk;
  logic                    rst_n_i;
  adc_raw_t   [NUM_CH-1:0] adc_dat;
  chan_pair_t              asg_dat;
  chan_pair_t              pid_dat;
  sys_req_t                sys_req;
  sys_rsp_t                sys_rsp;
  chan_pair_t              adc_out;
  dac_code_t  [NUM_CH-1:0] dac_out;
  logic                    dac_rst;
  logic      [PWM_CNT-1:0] pwm;

  chan_pair_t              exp_adc_n;       // Expected, set with the drive
  chan_pair_t              exp_adc_c;       // Expected, due this cycle
  dac_code_t  [NUM_CH-1:0] exp_dac_n;
  dac_code_t  [NUM_CH-1:0] exp_dac_c;
  logic                    vld_n;
  logic                    vld_c = 1'b0;
  logic                    loop_mode;       // Loopback expected in DUT
  logic [31:0]             rng;
  logic [31:0]             cyc;             // Cycles since reset release
  int                      err_cnt = 0;
  int                      chk_cnt = 0;

  rp_analog_top #(
    .PWM_CNT (PWM_CNT)
  ) i_dut (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .adc_dat_i (adc_dat),
    .asg_dat_i (asg_dat),
    .pid_dat_i (pid_dat),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp),
    .adc_dat_o (adc_out),
    .dac_dat_o (dac_out),
    .dac_rst_o (dac_rst),
    .pwm_o     (pwm    )
  );

  always #20 adc_clk = ~adc_clk;  // 40 ns period

  always @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cyc <= '0;
    else
      cyc <= cyc + 1;  // Low byte tracks the PWM period
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Upper 14 bits, MSB kept, rest inverted
  function automatic sample_t ref_adc(input adc_raw_t raw);
    return {raw[15], ~raw[14:2]};
  endfunction

  function automatic sample_t ref_dac_sat(input sample_t a, input sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > SMP_MAX)
      return sample_t'(SMP_MAX);
    if (s < SMP_MIN)
      return sample_t'(SMP_MIN);
    return sample_t'(s);
  endfunction

  function automatic dac_code_t ref_dac_code(input sample_t s);
    return {s[SMP_W-1], ~s[SMP_W-2:0]};
  endfunction

  function automatic chan_pair_t pair(input int a, input int b);
    chan_pair_t p;
    p.ch_a = sample_t'(a);
    p.ch_b = sample_t'(b);
    return p;
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
    chk_cnt++;
    if (got !== exp)
    begin
      $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  always @(posedge adc_clk)
  begin
    exp_adc_c <= exp_adc_n;  // One cycle of DUT latency
    exp_dac_c <= exp_dac_n;
    vld_c     <= vld_n;
  end

  always @(negedge adc_clk)
  begin : compare
    chan_pair_t loop_exp;
    loop_exp = pair(ref_dac_sat(asg_dat.ch_a, pid_dat.ch_a),
                    ref_dac_sat(asg_dat.ch_b, pid_dat.ch_b));  // Zero latency
    if (vld_c)
    begin
      if (loop_mode)
        check(adc_out, loop_exp, "adc_dat_o in loopback");
      else
        check(adc_out, exp_adc_c, "adc_dat_o");
      check(dac_out, exp_dac_c, "dac_dat_o");
    end
  end

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  task automatic drive_cycle(input adc_raw_t raw0, input adc_raw_t raw1,
                             input chan_pair_t asg, input chan_pair_t pid);
    @(posedge adc_clk);
    adc_dat[0]   <= raw0;
    adc_dat[1]   <= raw1;
    asg_dat      <= asg;
    pid_dat      <= pid;
    exp_adc_n    <= pair(ref_adc(raw0), ref_adc(raw1));
    exp_dac_n[0] <= ref_dac_code(ref_dac_sat(asg.ch_a, pid.ch_a));
    exp_dac_n[1] <= ref_dac_code(ref_dac_sat(asg.ch_b, pid.ch_b));
    vld_n        <= 1'b1;
  endtask

  task automatic drive_stop();
    @(posedge adc_clk);
    vld_n <= 1'b0;  // Last drive still checked
  endtask

  task automatic drive_random(input int n);
    logic [31:0] r0;
    logic [31:0] r1;
    for (int i = 0; i < n; i++)
    begin
      rng = xorshift32(rng);
      r0  = rng;
      rng = xorshift32(rng);
      r1  = rng;
      rng = xorshift32(rng);
      drive_cycle(r0[15:0], r0[31:16], pair(int'(sample_t'(r1[13:0])),
                  int'(sample_t'(r1[29:16]))), pair(int'(sample_t'(rng[13:0])),
                  int'(sample_t'(rng[29:16]))));
    end
    drive_stop();
  endtask

  // One strobe, then wait for the ack
  task automatic bus_access(input logic wr, input logic [BUS_AW-1:0] addr,
                            input logic [BUS_DW-1:0] wdata,
                            output logic [BUS_DW-1:0] rdata, output logic err);
    int wait_cnt;
    wait_cnt = 0;
    @(posedge adc_clk);
    sys_req.addr  <= addr;
    sys_req.wdata <= wdata;
    sys_req.wen   <= wr;
    sys_req.ren   <= !wr;
    @(posedge adc_clk);
    sys_req.wen   <= 1'b0;
    sys_req.ren   <= 1'b0;
    @(negedge adc_clk);
    while (!sys_rsp.ack && (wait_cnt < BUS_TIMEOUT))
    begin
      @(negedge adc_clk);
      wait_cnt++;
    end
    if (!sys_rsp.ack)
    begin
      $display("Timeout, no bus acknowledge for address %0h", addr);
      err_cnt++;
    end
    else
      check(wait_cnt, 0, "ack not one cycle after strobe");
    rdata = sys_rsp.rdata;
    err   = sys_rsp.err;
  endtask

  // Stops on the first cycle of a new PWM period
  task automatic wait_wrap();
    int wait_cnt;
    wait_cnt = 0;
    @(negedge adc_clk);
    while ((cyc[PWM_W-1:0] != '0) && (wait_cnt < WRAP_TIMEOUT))
    begin
      @(negedge adc_clk);
      wait_cnt++;
    end
    if (cyc[PWM_W-1:0] != '0)
    begin
      $display("Timeout, no PWM period start within %0d cycles", WRAP_TIMEOUT);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin : main
    logic [BUS_DW-1:0] rdata;
    logic              err;
    logic [PWM_W-1:0]  duty_wr [PWM_CNT];
    logic [PWM_W-1:0]  duties [4];
    int                hi [PWM_CNT];
    int                errs;
    adc_clk   = 1'b0;
    rst_n_i   = 1'b0;
    adc_dat   = '0;
    asg_dat   = '0;
    pid_dat   = '0;
    sys_req   = '0;
    vld_n     = 1'b0;
    loop_mode = 1'b0;
    rng       = 32'h24d0c15e;
    duties[0] = 8'd0;
    duties[1] = 8'd1;
    duties[2] = 8'd128;
    duties[3] = 8'd255;

    // Reset and post-reset state
    errs = err_cnt;
    repeat (15) @(posedge adc_clk);
    @(negedge adc_clk);
    check(dac_rst, 1'b1, "dac_rst_o in reset");
    check(dac_out, {NUM_CH{14'h1FFF}}, "dac_dat_o in reset");
    check(adc_out, '0, "adc_dat_o in reset");
    @(posedge adc_clk);
    rst_n_i <= 1'b1;  // After 16 cycles
    @(posedge adc_clk);
    @(negedge adc_clk);
    check(dac_rst, 1'b0, "dac_rst_o after reset");
    check(dac_out, {NUM_CH{14'h1FFF}}, "dac_dat_o after reset");
    check(pwm, '0, "pwm_o after reset");
    report_test("reset", errs);

    // Register access
    errs = err_cnt;
    bus_access(1'b0, REG_ID, '0, rdata, err);
    check(rdata, HK_ID, "ID read data");
    check(err, 1'b0, "ID read err");
    for (int v = 1; v >= 0; v--)
    begin
      bus_access(1'b1, REG_CFG, v, rdata, err);
      check(err, 1'b0, "CFG write err");
      bus_access(1'b0, REG_CFG, '0, rdata, err);
      check(rdata, v, "CFG readback");
    end
    for (int n = 0; n < PWM_CNT; n++)
    begin
      rng        = xorshift32(rng);
      duty_wr[n] = rng[PWM_W-1:0];
      bus_access(1'b1, REG_PWM0 + 12'(4 * n), duty_wr[n], rdata, err);
      check(err, 1'b0, "PWM write err");
    end
    for (int n = 0; n < PWM_CNT; n++)
    begin
      bus_access(1'b0, REG_PWM0 + 12'(4 * n), '0, rdata, err);
      check(rdata, duty_wr[n], $sformatf("PWM%0d readback", n));
    end
    bus_access(1'b0, 12'h100, '0, rdata, err);
    check(err, 1'b1, "unmapped read err");
    bus_access(1'b1, REG_ID, 32'h1234_5678, rdata, err);
    check(err, 1'b1, "ID write err");
    report_test("bus", errs);

    // ADC conversion with random raw words
    errs = err_cnt;
    drive_random(40);
    report_test("adc", errs);

    // DAC mixing, random then saturation corners
    errs = err_cnt;
    drive_random(30);
    drive_cycle('0, '0, pair(SMP_MAX, SMP_MIN), pair(SMP_MAX, SMP_MIN));
    drive_cycle('0, '0, pair(SMP_MAX, SMP_MIN), pair(1, -1));
    drive_cycle('0, '0, pair(SMP_MAX, SMP_MIN), pair(0, 0));
    drive_cycle('0, '0, pair(SMP_MIN, SMP_MAX), pair(SMP_MAX, SMP_MIN));
    drive_stop();
    report_test("dac", errs);

    // Loopback on, then off again
    errs = err_cnt;
    bus_access(1'b1, REG_CFG, 32'd1, rdata, err);
    loop_mode = 1'b1;
    drive_random(20);
    bus_access(1'b1, REG_CFG, 32'd0, rdata, err);
    loop_mode = 1'b0;
    drive_random(10);
    report_test("loopback", errs);

    // PWM duty, high cycles over one full period
    errs = err_cnt;
    for (int d = 0; d < 4; d++)
    begin
      for (int n = 0; n < PWM_CNT; n++)
        bus_access(1'b1, REG_PWM0 + 12'(4 * n), duties[d], rdata, err);
      wait_wrap();
      for (int n = 0; n < PWM_CNT; n++)
        hi[n] = 0;
      for (int c = 0; c < 256; c++)
      begin
        for (int n = 0; n < PWM_CNT; n++)
          hi[n] += pwm[n];
        @(negedge adc_clk);
      end
      for (int n = 0; n < PWM_CNT; n++)
        check(hi[n], duties[d], $sformatf("PWM%0d high cycles", n));
    end
    report_test("pwm", errs);

    $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule : tb_rp_analog_top

// ==== src/rp_analog_top.sv ====
// Analog signal path top
// ADC capture with loopback, DAC mixing, housekeeping registers on the
// system bus and the PWM analog outputs, all on the ADC clock

`timescale 1ns/1ps

module rp_analog_top
  import rp_analog_pkg::*;
#(
  parameter int unsigned PWM_CNT = 4  // PWM analog outputs
)(
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  // Converter side
  input  adc_raw_t   [NUM_CH-1:0]  adc_dat_i,
  input  chan_pair_t               asg_dat_i,  // Generator samples
  input  chan_pair_t               pid_dat_i,  // Controller samples
  // System bus
  input  sys_req_t                 sys_req_i,
  output sys_rsp_t                 sys_rsp_o,
  // Outputs
  output chan_pair_t               adc_dat_o,  // Converted ADC samples
  output dac_code_t  [NUM_CH-1:0]  dac_dat_o,
  output logic                     dac_rst_o,
  output logic       [PWM_CNT-1:0] pwm_o
);

  logic                          digital_loop;
  chan_pair_t                    dac_smp;   // Saturated mix for loopback
  logic [PWM_CNT-1:0][PWM_W-1:0] pwm_duty;

  ////////////////////////////////////////
  // ADC and DAC paths
  ////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .adc_dat_i      (adc_dat_i   ),
    .digital_loop_i (digital_loop),
    .dac_smp_i      (dac_smp     ),
    .adc_dat_o      (adc_dat_o   )
  );

  dac_backend i_dac (
    .adc_clk   (adc_clk  ),
    .rst_n_i   (rst_n_i  ),
    .asg_dat_i (asg_dat_i),
    .pid_dat_i (pid_dat_i),
    .dac_smp_o (dac_smp  ),
    .dac_dat_o (dac_dat_o),
    .dac_rst_o (dac_rst_o)
  );

  ////////////////////////////////////////
  // Housekeeping and PWM
  ////////////////////////////////////////

  hk_regs #(
    .PWM_CNT (PWM_CNT)
  ) i_hk (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .sys_req_i      (sys_req_i   ),
    .sys_rsp_o      (sys_rsp_o   ),
    .digital_loop_o (digital_loop),
    .pwm_duty_o     (pwm_duty    )
  );

  for (genvar i = 0; i < PWM_CNT; i++)
  begin : g_pwm
    pwm_dac i_pwm (
      .adc_clk (adc_clk    ),
      .rst_n_i (rst_n_i    ),
      .duty_i  (pwm_duty[i]),
      .pwm_o   (pwm_o[i]   )
    );
  end

endmodule : rp_analog_top

// ==== src/pwm_dac.sv ====
// PWM analog output
// Free-running period counter, duty taken over at each period start so the
// output is high for exactly duty cycles out of 256

`timescale 1ns/1ps

module pwm_dac
  import rp_analog_pkg::*;
(
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  logic [PWM_W-1:0]  duty_i,  // From housekeeping
  output logic              pwm_o
);

  logic [PWM_W-1:0] cnt_q;   // Period counter
  logic [PWM_W-1:0] duty_q;  // Duty of the running period

  ////////////////////////////////////////
  // Period counter and duty latch
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q  <= '0;
      duty_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;  // Wraps every 256 cycles
      // Load on the last count, new duty valid from counter zero
      if (cnt_q == {PWM_W{1'b1}})
        duty_q <= duty_i;
    end
  end

  // High for counts 0 .. duty-1
  assign pwm_o = (cnt_q < duty_q);

endmodule : pwm_dac

// ==== src/hk_regs.sv ====
// Housekeeping registers
// System bus slave holding the ID word, the loopback enable and the PWM
// duty settings. Ack and err come one cycle after the strobe

`timescale 1ns/1ps

module hk_regs
  import rp_analog_pkg::*;
#(
  parameter int unsigned PWM_CNT = 4
)(
  input  logic                           adc_clk,
  input  logic                           rst_n_i,
  input  sys_req_t                       sys_req_i,
  output sys_rsp_t                       sys_rsp_o,
  output logic                           digital_loop_o,
  output logic [PWM_CNT-1:0][PWM_W-1:0]  pwm_duty_o
);

  logic                          loop_q;    // CFG bit 0
  logic [PWM_CNT-1:0][PWM_W-1:0] duty_q;    // PWM duties
  logic [BUS_DW-1:0]             rdata_q;
  logic                          ack_q;
  logic                          err_q;

  logic [BUS_AW-1:0]             pwm_off;   // Offset into PWM block
  logic [BUS_AW-3:0]             pwm_idx;   // PWM channel number
  logic                          pwm_hit;
  logic                          addr_hit;  // Any mapped register
  logic [BUS_DW-1:0]             rd_mux;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign pwm_off = sys_req_i.addr - REG_PWM0;
  assign pwm_idx = pwm_off[BUS_AW-1:2];
  assign pwm_hit = (sys_req_i.addr >= REG_PWM0) && (pwm_idx < PWM_CNT) &&
                   (pwm_off[1:0] == 2'b00);  // Word aligned only

  always_comb
  begin
    rd_mux   = '0;
    addr_hit = 1'b1;
    if (sys_req_i.addr == REG_ID)
      rd_mux = HK_ID;
    else if (sys_req_i.addr == REG_CFG)
      rd_mux[0] = loop_q;
    else if (pwm_hit)
      rd_mux[PWM_W-1:0] = duty_q[pwm_idx];
    else
      addr_hit = 1'b0;  // Unmapped
  end

  ////////////////////////////////////////
  // Registers and response
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      loop_q <= 1'b0;
      duty_q <= '0;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
    end
    else
    begin
      if (sys_req_i.wen && (sys_req_i.addr == REG_CFG))
        loop_q <= sys_req_i.wdata[0];
      if (sys_req_i.wen && pwm_hit)
        duty_q[pwm_idx] <= sys_req_i.wdata[PWM_W-1:0];
      ack_q <= sys_req_i.wen | sys_req_i.ren;  // Single cycle pulse
      // ID is read only, writing it is an error
      err_q <= (sys_req_i.wen | sys_req_i.ren) &
               (~addr_hit | (sys_req_i.wen & (sys_req_i.addr == REG_ID)));
    end
  end

  // Read data, valid with ack
  always_ff @(posedge adc_clk)
  begin
    if (sys_req_i.ren)
      rdata_q <= rd_mux;
  end

  assign sys_rsp_o.rdata = rdata_q;
  assign sys_rsp_o.ack   = ack_q;
  assign sys_rsp_o.err   = err_q;

  assign digital_loop_o = loop_q;
  assign pwm_duty_o     = duty_q;

endmodule : hk_regs

// ==== src/dac_backend.sv ====
// DAC back end
// Adds generator and controller streams per channel, saturates to the
// sample range and registers the neg-slope DAC codes and the DAC reset

`timescale 1ns/1ps

module dac_backend
  import rp_analog_pkg::*;
(
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  chan_pair_t               asg_dat_i,  // Generator stream
  input  chan_pair_t               pid_dat_i,  // Controller stream
  output chan_pair_t               dac_smp_o,  // Saturated, unregistered
  output dac_code_t  [NUM_CH-1:0]  dac_dat_o,  // Registered DAC codes
  output logic                     dac_rst_o   // Active high
);

  // Code driven while in reset, mid-scale
  localparam dac_code_t DAC_MID = {1'b0, {(SMP_W-1){1'b1}}};

  sample_t [NUM_CH-1:0] asg_s;
  sample_t [NUM_CH-1:0] pid_s;
  sample_t [NUM_CH-1:0] sat_s;

  // Struct fields to channel arrays
  assign asg_s[0] = asg_dat_i.ch_a;
  assign asg_s[1] = asg_dat_i.ch_b;
  assign pid_s[0] = pid_dat_i.ch_a;
  assign pid_s[1] = pid_dat_i.ch_b;

  ////////////////////////////////////////
  // Sum and saturation
  ////////////////////////////////////////

  for (genvar ch = 0; ch < NUM_CH; ch++)
  begin : g_sum
    logic signed [SMP_W:0] sum;  // One guard bit

    assign sum = asg_s[ch] + pid_s[ch];

    // Top two bits differ on overflow, clamp to the signed extremes
    assign sat_s[ch] = (^sum[SMP_W -: 2]) ? {sum[SMP_W], {(SMP_W-1){~sum[SMP_W]}}}
                                          : sum[SMP_W-1:0];
  end

  assign dac_smp_o.ch_a = sat_s[0];  // Loopback source
  assign dac_smp_o.ch_b = sat_s[1];

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_o <= {NUM_CH{DAC_MID}};
      dac_rst_o <= 1'b1;  // Held while in reset
    end
    else
    begin
      for (int ch = 0; ch < NUM_CH; ch++)
        dac_dat_o[ch] <= {sat_s[ch][SMP_W-1], ~sat_s[ch][SMP_W-2:0]};  // Neg-slope
      dac_rst_o <= 1'b0;  // Released on first edge
    end
  end

endmodule : dac_backend

// ==== src/adc_frontend.sv ====
// ADC front end
// Registers the raw converter words, turns the neg-slope code into two's
// complement and optionally swaps in the DAC samples for digital loopback

`timescale 1ns/1ps

module adc_frontend
  import rp_analog_pkg::*;
(
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  adc_raw_t   [NUM_CH-1:0]  adc_dat_i,       // Raw pin words
  input  logic                     digital_loop_i,  // Loopback enable
  input  chan_pair_t               dac_smp_i,       // Saturated DAC samples
  output chan_pair_t               adc_dat_o
);

  // Mid-scale raw code, converts to a zero sample
  localparam logic [SMP_W-1:0] RAW_ZERO = {1'b0, {(SMP_W-1){1'b1}}};

  logic    [NUM_CH-1:0][SMP_W-1:0] raw_q;     // Input registers
  sample_t [NUM_CH-1:0]            adc_conv;  // Converted samples
  chan_pair_t                      adc_pair;

  // Input registers, lowest bits kept free for a 16-bit ADC
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      raw_q <= {NUM_CH{RAW_ZERO}};
    else
    begin
      for (int ch = 0; ch < NUM_CH; ch++)
        raw_q[ch] <= adc_dat_i[ch][ADC_RAW_W-1 -: SMP_W];  // Drop 2 LSBs
    end
  end

  // Neg-slope to two's complement
  for (genvar ch = 0; ch < NUM_CH; ch++)
  begin : g_conv
    assign adc_conv[ch] = {raw_q[ch][SMP_W-1], ~raw_q[ch][SMP_W-2:0]};
  end

  assign adc_pair.ch_a = adc_conv[0];
  assign adc_pair.ch_b = adc_conv[1];

  // Loopback bypasses the converter path with zero latency
  assign adc_dat_o = digital_loop_i ? dac_smp_i : adc_pair;

endmodule : adc_frontend

// ==== src/rp_analog_pkg.sv ====
// Analog path shared definitions
// Sample widths, converter code types, system bus structs and the
// housekeeping register map

package rp_analog_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int unsigned ADC_RAW_W = 16;  // Raw ADC pin word
  localparam int unsigned SMP_W     = 14;  // Sample and DAC code
  localparam int unsigned NUM_CH    = 2;   // Analog channels
  localparam int unsigned PWM_W     = 8;   // PWM duty setting
  localparam int unsigned BUS_AW    = 12;  // System bus address
  localparam int unsigned BUS_DW    = 32;  // System bus data

  ////////////////////////////////////////
  // Sample and code types
  ////////////////////////////////////////

  typedef logic        [ADC_RAW_W-1:0] adc_raw_t;   // Unsigned neg-slope, 2 LSBs reserved
  typedef logic signed [SMP_W-1:0]     sample_t;    // Two's complement
  typedef logic        [SMP_W-1:0]     dac_code_t;  // Unsigned neg-slope

  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
  } chan_pair_t;

  ////////////////////////////////////////
  // System bus
  ////////////////////////////////////////

  // Request, strobes last one cycle
  typedef struct packed {
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
    logic              wen;
    logic              ren;
  } sys_req_t;

  // Response, ack one cycle after the strobe
  typedef struct packed {
    logic [BUS_DW-1:0] rdata;
    logic              ack;
    logic              err;
  } sys_rsp_t;

  // Register map
  localparam logic [BUS_AW-1:0] REG_ID   = 12'h000;  // Read only
  localparam logic [BUS_AW-1:0] REG_CFG  = 12'h004;  // Bit 0 loopback
  localparam logic [BUS_AW-1:0] REG_PWM0 = 12'h010;  // PWM n at +4*n

  localparam logic [BUS_DW-1:0] HK_ID    = 32'h5250_0001;

endpackage : rp_analog_pkg
